//--- rv_decoder.f
+incdir+verilog
verilog/rv_decoder_pkg.sv
verilog/decode_format_stage.sv
verilog/decode_ctrl_stage.sv
verilog/decode_operand_stage.sv
verilog/rv_decoder_top.sv
verif/rv_decoder_tb.sv

//--- verif/rv_decoder_tb.sv
// Testbench for the RV32I decoder
// Directed and random instruction streams checked against a reference decode
`include "rv_decoder_params.svh"

module rv_decoder_tb
    import rv_decoder_pkg::*;
();

    localparam int TIMEOUT  = 500;
    localparam int DIRECTED = 288;
    localparam int N_RANDOM = 600;

    localparam logic [62:0] OPCODES = {`OPC_OP, `OPC_OPIMM, `OPC_STORE, `OPC_LOAD,
        `OPC_BRANCH, `OPC_JALR, `OPC_JAL, `OPC_AUIPC, `OPC_LUI};
    // ALU codes by funct3 with NOP in the holes
    localparam logic [47:0] ARITH_CODES = {`ALU_AND, `ALU_OR, `ALU_SRL, `ALU_XOR,
        `ALU_SLTU, `ALU_SLT, `ALU_SLL, `ALU_ADD};
    localparam logic [47:0] BRANCH_CODES = {`ALU_BGEU, `ALU_BLTU, `ALU_BGE, `ALU_BLT,
        `ALU_NOP, `ALU_NOP, `ALU_BNE, `ALU_BEQ};
    localparam logic [47:0] LOAD_CODES = {`ALU_NOP, `ALU_NOP, `ALU_LHU, `ALU_LBU,
        `ALU_NOP, `ALU_LW, `ALU_LH, `ALU_LB};
    localparam logic [47:0] STORE_CODES = {`ALU_NOP, `ALU_NOP, `ALU_NOP, `ALU_NOP,
        `ALU_NOP, `ALU_SW, `ALU_SH, `ALU_SB};

    logic     clk;
    logic     rst;
    logic     in_valid;
    insn_t    in_insn;
    logic     in_ready;
    logic     out_valid;
    dec_out_t out_pkt;
    logic     out_ready;

    integer   seed;
    string    test_name;
    logic     bp_mode;
    int       hold_cnt;
    insn_t    words[$];
    dec_out_t exp_q[$];

    rv_decoder_top rv_decoder_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_insn   (in_insn),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic dec_ctrl_t make_ctrl(input alucode_t code, input op_type_t op1,
                                            input op_type_t op2, input logic we,
                                            input logic ld, input logic st);
        return '{alucode: code, aluop1_type: op1, aluop2_type: op2,
                 reg_we: we, is_load: ld, is_store: st};
    endfunction

    function automatic dec_out_t decode_ref(input insn_t w);
        dec_out_t   r;
        insn_fmt_t  fmt;
        alucode_t   code;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       link_we;
        f3 = w[14:12];
        f7 = w[31:25];
        link_we = w[11:7] != 5'd0;     // No link write to x0
        r = '0;
        r.ctrl = make_ctrl(`ALU_NOP, `OPT_NONE, `OPT_NONE, 1'b0, 1'b0, 1'b0);
        fmt = `FMT_NONE;
        case (w[6:0])
            `OPC_LUI: begin
                fmt = `FMT_U;
                r.ctrl = make_ctrl(`ALU_LUI, `OPT_NONE, `OPT_IMM, 1'b1, 1'b0, 1'b0);
            end
            `OPC_AUIPC: begin
                fmt = `FMT_U;
                r.ctrl = make_ctrl(`ALU_ADD, `OPT_IMM, `OPT_PC, 1'b1, 1'b0, 1'b0);
            end
            `OPC_JAL: begin
                fmt = `FMT_J;
                r.ctrl = make_ctrl(`ALU_JAL, `OPT_NONE, `OPT_PC, link_we, 1'b0, 1'b0);
            end
            `OPC_JALR: begin
                fmt = `FMT_I;
                r.ctrl = make_ctrl(`ALU_JALR, `OPT_REG, `OPT_PC, link_we, 1'b0, 1'b0);
            end
            `OPC_BRANCH: begin
                code = BRANCH_CODES[f3*6 +: 6];
                if (code != `ALU_NOP) begin
                    fmt = `FMT_B;
                    r.ctrl = make_ctrl(code, `OPT_REG, `OPT_REG, 1'b0, 1'b0, 1'b0);
                end
            end
            `OPC_LOAD: begin
                code = LOAD_CODES[f3*6 +: 6];
                if (code != `ALU_NOP) begin
                    fmt = `FMT_I;
                    r.ctrl = make_ctrl(code, `OPT_REG, `OPT_IMM, 1'b1, 1'b1, 1'b0);
                end
            end
            `OPC_STORE: begin
                code = STORE_CODES[f3*6 +: 6];
                if (code != `ALU_NOP) begin
                    fmt = `FMT_S;
                    r.ctrl = make_ctrl(code, `OPT_REG, `OPT_IMM, 1'b0, 1'b0, 1'b1);
                end
            end
            `OPC_OPIMM: begin
                code = ARITH_CODES[f3*6 +: 6];
                if (f3 == 3'b101 && f7[5]) begin
                    code = `ALU_SRA;   // SRAI
                end
                fmt = `FMT_I;
                r.ctrl = make_ctrl(code, `OPT_REG, `OPT_IMM, 1'b1, 1'b0, 1'b0);
            end
            `OPC_OP: begin
                code = ARITH_CODES[f3*6 +: 6];
                if (f7 == 7'h20) begin
                    code = (f3 == 3'b000) ? `ALU_SUB : (f3 == 3'b101) ? `ALU_SRA : `ALU_NOP;
                end else if (f7 != 7'h00) begin
                    code = `ALU_NOP;   // M extension and others
                end
                if (code != `ALU_NOP) begin
                    fmt = `FMT_R;
                    r.ctrl = make_ctrl(code, `OPT_REG, `OPT_REG, 1'b1, 1'b0, 1'b0);
                end
            end
            default: fmt = `FMT_NONE;
        endcase
        r.srcreg1_num = (fmt == `FMT_U || fmt == `FMT_J) ? 5'd0 : w[19:15];
        r.srcreg2_num = (fmt == `FMT_U || fmt == `FMT_J || fmt == `FMT_I) ? 5'd0 : w[24:20];
        r.dstreg_num  = (fmt == `FMT_S || fmt == `FMT_B || fmt == `FMT_NONE) ? 5'd0 : w[11:7];
        case (fmt)
            `FMT_U: r.imm = w & 32'hffff_f000;
            `FMT_I: r.imm = $signed(w) >>> 20;
            `FMT_S: r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            `FMT_B: r.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            `FMT_J: r.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: r.imm = '0;
        endcase
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("Run stopped in test %s: %s", test_name, why);
        $display("** FAIL **");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_word(input insn_t w);
        int waited;
        waited = 0;
        in_valid = 1'b1;
        in_insn = w;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) stop_run("in_ready stayed low");
        end while (!in_ready);
        #1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) stop_run("pipeline did not drain");
        end
    endtask

    // Scoreboard fill on every accepted word
    always @(posedge clk) begin
        if (!rst && in_valid && in_ready) begin
            exp_q.push_back(decode_ref(in_insn));
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) stop_run("output packet with no word outstanding");
            check({test_name, "/packet"}, exp_q.pop_front(), out_pkt);
        end
    end

    // Random back-pressure with occasional long stalls
    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        if (bp_mode) begin
            if (hold_cnt > 0) begin
                hold_cnt--;
            end else begin
                r = $random(seed);
                if (r[3:0] == 4'd0) begin
                    out_ready = 1'b0;
                    hold_cnt = 20 + r[8:4];
                end else begin
                    out_ready = r[4];
                    hold_cnt = r[6:5];
                end
            end
        end
    end

    initial begin
        int          i;
        int          f3v;
        int          v;
        int          n;
        int          pick;
        int          waited;
        logic        accepted;
        logic [31:0] r;
        logic [6:0]  f7;
        rst = 1'b1;
        in_valid = 1'b0;
        in_insn = '0;
        out_ready = 1'b1;
        bp_mode = 1'b0;
        hold_cnt = 0;
        seed = 32'h40c7_fd6d;
        test_name = "reset";

        // Every opcode and funct3, with base, alternate, M and negative funct7
        for (i = 0; i < 9; i++) begin
            for (f3v = 0; f3v < 8; f3v++) begin
                for (v = 0; v < 4; v++) begin
                    r = $random(seed);
                    case (v)
                        0: f7 = 7'h00;
                        1: f7 = 7'h20;
                        2: f7 = 7'h01;
                        default: f7 = r[31:25] | 7'h40;
                    endcase
                    words.push_back({f7, r[24:15], f3v[2:0], (v == 0) ? 5'd0 : r[11:7],
                                     OPCODES[i*7 +: 7]});
                end
            end
        end
        for (i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            pick = $unsigned($random(seed)) % 54;
            if (pick % 6 != 0) begin
                words.push_back({r[31:7], OPCODES[(pick / 6)*7 +: 7]});
            end else if (r[0]) begin
                words.push_back({7'h01, r[24:7], `OPC_OP});
            end else begin
                words.push_back(r);    // Random opcode
            end
        end

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check({test_name, "/in_ready"}, 1, in_ready);
        check({test_name, "/out_valid"}, 0, out_valid);

        test_name = "directed";
        for (i = 0; i < DIRECTED; i++) begin
            send_word(words.pop_front());
        end
        in_valid = 1'b0;
        wait_drain();

        test_name = "latency";
        send_word(32'hfff0_0293);      // addi x5, x0, -1
        in_valid = 1'b0;
        waited = 0;
        // Output transfer lands on the third edge after acceptance
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) stop_run("out_valid never rose");
        end while (!out_valid);
        #1;
        check({test_name, "/cycles"}, 3, waited);
        wait_drain();

        test_name = "fill";
        out_ready = 1'b0;
        n = 0;
        in_valid = 1'b1;
        in_insn = words.pop_front();
        repeat (6) begin
            @(posedge clk);
            accepted = in_ready;
            #1;
            if (accepted) begin
                n++;
                in_insn = words.pop_front();
            end
        end
        in_valid = 1'b0;
        check({test_name, "/accepted"}, 3, n);
        check({test_name, "/in_ready"}, 0, in_ready);
        out_ready = 1'b1;
        wait_drain();

        test_name = "backpressure";
        bp_mode = 1'b1;
        while (words.size() > 0) begin
            send_word(words.pop_front());
        end
        in_valid = 1'b0;
        wait_drain();
        bp_mode = 1'b0;
        out_ready = 1'b1;

        $display("** PASS **");
        $finish;
    end

endmodule

//--- verilog/decode_ctrl_stage.sv
// Decoder stage 2
// Turns opcode, funct3 and funct7 into the ALU code and control bundle
`include "rv_decoder_params.svh"

module decode_ctrl_stage
    import rv_decoder_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      up_valid,
    input  fmt_pkt_t  up_pkt,
    output logic      up_ready,
    output logic      dn_valid,
    output ctrl_pkt_t dn_pkt,
    input  logic      dn_ready
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_nonzero;
    dec_ctrl_t  ctrl;

    // Shared by OP and OP-IMM
    function automatic alucode_t arith_alu(input logic [2:0] f3, input logic sub,
                                           input logic sra);
        alucode_t code;
        case (f3)
            `F3_ADD_SUB: code = sub ? `ALU_SUB : `ALU_ADD;
            3'b001:      code = `ALU_SLL;
            3'b010:      code = `ALU_SLT;
            3'b011:      code = `ALU_SLTU;
            3'b100:      code = `ALU_XOR;
            `F3_SRL_SRA: code = sra ? `ALU_SRA : `ALU_SRL;
            3'b110:      code = `ALU_OR;
            default:     code = `ALU_AND;
        endcase
        return code;
    endfunction

    assign opcode     = opcode_of(up_pkt.insn);
    assign funct3     = funct3_of(up_pkt.insn);
    assign funct7     = funct7_of(up_pkt.insn);
    assign rd_nonzero = rd_of(up_pkt.insn) != '0;

    always_comb begin
        ctrl = CTRL_NOP;
        if (up_pkt.fmt != `FMT_NONE) begin
            case (opcode)
                `OPC_LUI: begin
                    ctrl.alucode     = `ALU_LUI;
                    ctrl.aluop2_type = `OPT_IMM;
                    ctrl.reg_we      = 1'b1;
                end
                `OPC_AUIPC: begin
                    ctrl.alucode     = `ALU_ADD;
                    ctrl.aluop1_type = `OPT_IMM;
                    ctrl.aluop2_type = `OPT_PC;
                    ctrl.reg_we      = 1'b1;
                end
                `OPC_JAL: begin
                    ctrl.alucode     = `ALU_JAL;
                    ctrl.aluop2_type = `OPT_PC;
                    ctrl.reg_we      = rd_nonzero;  // No link write to x0
                end
                `OPC_JALR: begin
                    ctrl.alucode     = `ALU_JALR;
                    ctrl.aluop1_type = `OPT_REG;
                    ctrl.aluop2_type = `OPT_PC;
                    ctrl.reg_we      = rd_nonzero;
                end
                `OPC_BRANCH: begin
                    ctrl.aluop1_type = `OPT_REG;
                    ctrl.aluop2_type = `OPT_REG;
                    case (funct3)
                        3'b000:  ctrl.alucode = `ALU_BEQ;
                        3'b001:  ctrl.alucode = `ALU_BNE;
                        3'b100:  ctrl.alucode = `ALU_BLT;
                        3'b101:  ctrl.alucode = `ALU_BGE;
                        3'b110:  ctrl.alucode = `ALU_BLTU;
                        3'b111:  ctrl.alucode = `ALU_BGEU;
                        default: ctrl = CTRL_NOP;
                    endcase
                end
                `OPC_LOAD: begin
                    ctrl.aluop1_type = `OPT_REG;
                    ctrl.aluop2_type = `OPT_IMM;
                    ctrl.reg_we      = 1'b1;
                    ctrl.is_load     = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.alucode = `ALU_LB;
                        3'b001:  ctrl.alucode = `ALU_LH;
                        3'b010:  ctrl.alucode = `ALU_LW;
                        3'b100:  ctrl.alucode = `ALU_LBU;
                        3'b101:  ctrl.alucode = `ALU_LHU;
                        default: ctrl = CTRL_NOP;
                    endcase
                end
                `OPC_STORE: begin
                    ctrl.aluop1_type = `OPT_REG;
                    ctrl.aluop2_type = `OPT_IMM;
                    ctrl.is_store    = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.alucode = `ALU_SB;
                        3'b001:  ctrl.alucode = `ALU_SH;
                        3'b010:  ctrl.alucode = `ALU_SW;
                        default: ctrl = CTRL_NOP;
                    endcase
                end
                `OPC_OPIMM: begin
                    ctrl.alucode     = arith_alu(funct3, 1'b0, funct7[5]);  // No SUBI
                    ctrl.aluop1_type = `OPT_REG;
                    ctrl.aluop2_type = `OPT_IMM;
                    ctrl.reg_we      = 1'b1;
                end
                `OPC_OP: begin
                    ctrl.alucode     = arith_alu(funct3, funct7[5], funct7[5]);
                    ctrl.aluop1_type = `OPT_REG;
                    ctrl.aluop2_type = `OPT_REG;
                    ctrl.reg_we      = 1'b1;
                end
                default: ctrl = CTRL_NOP;
            endcase
        end
    end

    assign up_ready = !dn_valid || dn_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dn_valid <= 1'b0;
        end else if (up_ready) begin
            dn_valid <= up_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up_valid && up_ready) begin
            dn_pkt <= '{insn: up_pkt.insn, fmt: up_pkt.fmt, ctrl: ctrl};
        end
    end

    a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
        dn_valid |-> !(dn_pkt.ctrl.is_load && dn_pkt.ctrl.is_store));

endmodule

//--- verilog/decode_format_stage.sv
// Decoder stage 1
// Classifies the opcode into an instruction format and registers it with the word
`include "rv_decoder_params.svh"

module decode_format_stage
    import rv_decoder_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  insn_t    in_insn,
    output logic     in_ready,
    output logic     dn_valid,
    output fmt_pkt_t dn_pkt,
    input  logic     dn_ready
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    insn_fmt_t  fmt;

    assign opcode = opcode_of(in_insn);
    assign funct3 = funct3_of(in_insn);
    assign funct7 = funct7_of(in_insn);

    always_comb begin
        fmt = `FMT_NONE;
        case (opcode)
            `OPC_LUI, `OPC_AUIPC: fmt = `FMT_U;
            `OPC_JAL:             fmt = `FMT_J;
            `OPC_JALR, `OPC_OPIMM: fmt = `FMT_I;
            `OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    fmt = `FMT_I;
                end
            end
            `OPC_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    fmt = `FMT_S;
                end
            end
            `OPC_BRANCH: begin
                if (!(funct3 inside {3'b010, 3'b011})) begin
                    fmt = `FMT_B;
                end
            end
            `OPC_OP: begin
                // Alternate funct7 only for SUB and SRA, M encodings rejected
                if (funct7 == `F7_BASE ||
                    (funct7 == `F7_ALT && funct3 inside {`F3_ADD_SUB, `F3_SRL_SRA})) begin
                    fmt = `FMT_R;
                end
            end
            default: fmt = `FMT_NONE;
        endcase
    end

    assign in_ready = !dn_valid || dn_ready;    // Empty or draining

    always_ff @(posedge clk) begin
        if (rst) begin
            dn_valid <= 1'b0;
        end else if (in_ready) begin
            dn_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dn_pkt <= '{insn: in_insn, fmt: fmt};
        end
    end

    // Stalled packet must not change under the consumer
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        dn_valid && !dn_ready |=> dn_valid && $stable(dn_pkt));

endmodule

//--- verilog/decode_operand_stage.sv
// Decoder stage 3
// Extracts register numbers, builds the immediate and registers the final packet
`include "rv_decoder_params.svh"

module decode_operand_stage
    import rv_decoder_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      up_valid,
    input  ctrl_pkt_t up_pkt,
    output logic      up_ready,
    output logic      out_valid,
    output dec_out_t  out_pkt,
    input  logic      out_ready
);

    insn_t     insn;
    insn_fmt_t fmt;
    reg_num_t  rs1;
    reg_num_t  rs2;
    reg_num_t  rd;
    word_t     imm;

    assign insn = up_pkt.insn;
    assign fmt  = up_pkt.fmt;

    // Unused register fields forced to x0
    assign rs1 = (fmt inside {`FMT_U, `FMT_J}) ? '0 : rs1_of(insn);
    assign rs2 = (fmt inside {`FMT_U, `FMT_J, `FMT_I}) ? '0 : rs2_of(insn);
    assign rd  = (fmt inside {`FMT_S, `FMT_B, `FMT_NONE}) ? '0 : rd_of(insn);

    always_comb begin
        case (fmt)
            `FMT_U: imm = {insn[31:12], 12'd0};
            `FMT_J: imm = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            `FMT_I: imm = {{20{insn[31]}}, insn[31:20]};
            `FMT_B: imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            `FMT_S: imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            default: imm = '0;     // R and invalid
        endcase
    end

    assign up_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (up_ready) begin
            out_valid <= up_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up_valid && up_ready) begin
            out_pkt <= '{
                srcreg1_num: rs1,
                srcreg2_num: rs2,
                dstreg_num:  rd,
                imm:         imm,
                ctrl:        up_pkt.ctrl
            };
        end
    end

    // A NOP leaving the decoder must never write the register file
    a_nop_no_we: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_pkt.ctrl.alucode == `ALU_NOP |-> !out_pkt.ctrl.reg_we);

endmodule

//--- verilog/rv_decoder_params.svh
// RV32I decoder constants
// Field widths, opcode and funct values, format, ALU and operand type codes
`ifndef RV_DECODER_PARAMS_SVH
`define RV_DECODER_PARAMS_SVH

`define RV_XLEN      32
`define RV_REG_W     5
`define RV_ALU_W     6
`define RV_FMT_W     3
`define RV_OPT_W     2

`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OPIMM    7'b0010011
`define OPC_OP       7'b0110011

`define F3_ADD_SUB   3'b000
`define F3_SRL_SRA   3'b101
`define F7_BASE      7'b0000000
`define F7_ALT       7'b0100000     // SUB and SRA

`define FMT_NONE     3'd0
`define FMT_U        3'd1
`define FMT_J        3'd2
`define FMT_I        3'd3
`define FMT_B        3'd4
`define FMT_S        3'd5
`define FMT_R        3'd6

`define ALU_LUI      6'd0
`define ALU_JAL      6'd1
`define ALU_JALR     6'd2
`define ALU_BEQ      6'd3
`define ALU_BNE      6'd4
`define ALU_BLT      6'd5
`define ALU_BGE      6'd6
`define ALU_BLTU     6'd7
`define ALU_BGEU     6'd8
`define ALU_LB       6'd9
`define ALU_LH       6'd10
`define ALU_LW       6'd11
`define ALU_LBU      6'd12
`define ALU_LHU      6'd13
`define ALU_SB       6'd14
`define ALU_SH       6'd15
`define ALU_SW       6'd16
`define ALU_ADD      6'd17
`define ALU_SUB      6'd18
`define ALU_XOR      6'd19
`define ALU_OR       6'd20
`define ALU_AND      6'd21
`define ALU_SLT      6'd22
`define ALU_SLTU     6'd23
`define ALU_SLL      6'd24
`define ALU_SRL      6'd25
`define ALU_SRA      6'd26
`define ALU_NOP      6'd63

`define OPT_NONE     2'd0
`define OPT_REG      2'd1
`define OPT_IMM      2'd2
`define OPT_PC       2'd3

`endif

//--- verilog/rv_decoder_pkg.sv
// RV32I decoder types
// Field typedefs, inter-stage packets and instruction field helpers
`include "rv_decoder_params.svh"

package rv_decoder_pkg;

    typedef logic [`RV_XLEN-1:0]  insn_t;
    typedef logic [`RV_XLEN-1:0]  word_t;
    typedef logic [`RV_REG_W-1:0] reg_num_t;
    typedef logic [`RV_ALU_W-1:0] alucode_t;
    typedef logic [`RV_FMT_W-1:0] insn_fmt_t;
    typedef logic [`RV_OPT_W-1:0] op_type_t;

    typedef struct packed {
        insn_t     insn;
        insn_fmt_t fmt;
    } fmt_pkt_t;

    typedef struct packed {
        alucode_t alucode;
        op_type_t aluop1_type;
        op_type_t aluop2_type;
        logic     reg_we;
        logic     is_load;
        logic     is_store;
    } dec_ctrl_t;

    typedef struct packed {
        insn_t     insn;
        insn_fmt_t fmt;
        dec_ctrl_t ctrl;
    } ctrl_pkt_t;

    typedef struct packed {
        reg_num_t  srcreg1_num;
        reg_num_t  srcreg2_num;
        reg_num_t  dstreg_num;
        word_t     imm;
        dec_ctrl_t ctrl;
    } dec_out_t;

    // Invalid or unknown encoding
    localparam dec_ctrl_t CTRL_NOP = '{
        alucode:     `ALU_NOP,
        aluop1_type: `OPT_NONE,
        aluop2_type: `OPT_NONE,
        reg_we:      1'b0,
        is_load:     1'b0,
        is_store:    1'b0
    };

    function automatic logic [6:0] opcode_of(input insn_t insn);
        return insn[6:0];
    endfunction

    function automatic logic [2:0] funct3_of(input insn_t insn);
        return insn[14:12];
    endfunction

    function automatic logic [6:0] funct7_of(input insn_t insn);
        return insn[31:25];
    endfunction

    function automatic reg_num_t rd_of(input insn_t insn);
        return insn[11:7];
    endfunction

    function automatic reg_num_t rs1_of(input insn_t insn);
        return insn[19:15];
    endfunction

    function automatic reg_num_t rs2_of(input insn_t insn);
        return insn[24:20];
    endfunction

endpackage

//--- verilog/rv_decoder_top.sv
// RV32I instruction decoder
// Three registered stages between the instruction stream and the decoded stream

module rv_decoder_top
    import rv_decoder_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  insn_t    in_insn,
    output logic     in_ready,
    output logic     out_valid,
    output dec_out_t out_pkt,
    input  logic     out_ready
);

    logic      fmt_valid;
    logic      fmt_ready;
    fmt_pkt_t  fmt_pkt;
    logic      ctrl_valid;
    logic      ctrl_ready;
    ctrl_pkt_t ctrl_pkt;

    decode_format_stage decode_format_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_insn  (in_insn),
        .in_ready (in_ready),
        .dn_valid (fmt_valid),
        .dn_pkt   (fmt_pkt),
        .dn_ready (fmt_ready)
    );

    decode_ctrl_stage decode_ctrl_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .up_valid (fmt_valid),
        .up_pkt   (fmt_pkt),
        .up_ready (fmt_ready),
        .dn_valid (ctrl_valid),
        .dn_pkt   (ctrl_pkt),
        .dn_ready (ctrl_ready)
    );

    decode_operand_stage decode_operand_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .up_valid  (ctrl_valid),
        .up_pkt    (ctrl_pkt),
        .up_ready  (ctrl_ready),
        .out_valid (out_valid),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

endmodule
